/* hdl/mfifo_params.svh */
// Multi-FIFO sizing constants shared by the packages and the RTL
`ifndef MFIFO_PARAMS_SVH
`define MFIFO_PARAMS_SVH

// Number of logical FIFOs sharing the storage
`define MFIFO_NUM_FIFOS 4

// Total entries in the shared RAM
`define MFIFO_DEPTH 16

// Payload width of one entry
`define MFIFO_WIDTH 16

// Derived widths
// FIFO index, clog2 of the FIFO count
`define MFIFO_ID_W 2
// RAM address, clog2 of the depth
`define MFIFO_ADDR_W 4
// Credit and occupancy counts, must hold the full depth
`define MFIFO_CNT_W 5

`endif

/* hdl/mfifo_cfg_pkg.sv */
// Multi-FIFO config types describing the static split of the shared RAM
`include "mfifo_params.svh"

package mfifo_cfg_pkg;

  // One region of the shared RAM
  // Both ends are inclusive, bound must not be below base
  typedef struct packed {
    logic [`MFIFO_ADDR_W-1:0] base;
    logic [`MFIFO_ADDR_W-1:0] bound;
  } region_t;

  // Region per FIFO, index is the FIFO id
  // Only changes while the design is held in reset
  typedef region_t [`MFIFO_NUM_FIFOS-1:0] region_map_t;

  // Regions must not overlap and together may use at most the full depth
  // Every FIFO owns at least one entry

endpackage

/* hdl/mfifo_xfer_pkg.sv */
// Multi-FIFO traffic types for push beats, RAM writes, pops and credit status
`include "mfifo_params.svh"

package mfifo_xfer_pkg;

  // Push beat from the credit sender, qualified by a separate strobe
  typedef struct packed {
    logic [`MFIFO_ID_W-1:0]  id;
    logic [`MFIFO_WIDTH-1:0] data;
  } push_beat_t;

  // Single write port into the shared RAM
  typedef struct packed {
    logic                     valid;
    logic [`MFIFO_ADDR_W-1:0] addr;
    logic [`MFIFO_WIDTH-1:0]  data;
  } ram_wr_t;

  // Pop strobe with the FIFO to read
  typedef struct packed {
    logic                   valid;
    logic [`MFIFO_ID_W-1:0] id;
  } pop_req_t;

  // Popped entry, one cycle after the accepted pop
  typedef struct packed {
    logic                    valid;
    logic [`MFIFO_ID_W-1:0]  id;
    logic [`MFIFO_WIDTH-1:0] data;
  } pop_data_t;

  // Credit state of one FIFO
  // avail is banked at the receiver, held is out at the sender
  typedef struct packed {
    logic [`MFIFO_CNT_W-1:0] avail;
    logic [`MFIFO_CNT_W-1:0] held;
  } credit_stat_t;

  typedef credit_stat_t [`MFIFO_NUM_FIFOS-1:0] credit_stat_vec_t;

endpackage

/* hdl/mfifo_credit_ctrl.sv */
// Multi-FIFO credit controller that counts, paces and returns push credits per FIFO
`timescale 1ns/10ps
`include "mfifo_params.svh"

module mfifo_credit_ctrl
  import mfifo_cfg_pkg::*;
  import mfifo_xfer_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_n,
  // Reset level from the credit sender
  input  logic                                          push_sender_in_reset,
  // Static partitioning, steady outside of reset
  input  region_map_t                                   region_cfg,
  // Credits kept back at the receiver, per FIFO
  input  logic [`MFIFO_NUM_FIFOS-1:0][`MFIFO_CNT_W-1:0] credit_withhold,
  // Push beat as seen at the receiver
  input  logic                                          push_valid,
  input  logic [`MFIFO_ID_W-1:0]                        push_id,
  // Entries released by the pop side
  input  logic [`MFIFO_NUM_FIFOS-1:0]                   free,
  // One-cycle credit pulses back to the sender
  output logic [`MFIFO_NUM_FIFOS-1:0]                   push_credit,
  output logic                                          push_receiver_in_reset,
  // Pointer clear for both pointer blocks
  output logic                                          ptr_clear,
  output credit_stat_vec_t                              credit_stat
);

  localparam int num_fifos = `MFIFO_NUM_FIFOS;
  localparam int cnt_w     = `MFIFO_CNT_W;

  // Either reset source empties the receiver
  logic int_rst;
  logic in_rst_q;

  assign int_rst = !rst_n || push_sender_in_reset;

  // Registered copy of the merged reset
  // High out of rst_n, follows the sender level afterwards
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_rst_q <= 1'b1;
    end else begin
      in_rst_q <= push_sender_in_reset;
    end
  end

  // Only one receiver-in-reset goes back, all FIFOs share it
  assign push_receiver_in_reset = in_rst_q;
  assign ptr_clear              = in_rst_q;

  for (genvar i = 0; i < num_fifos; i++) begin : gen_fifo
    logic [cnt_w-1:0] size;
    logic [cnt_w-1:0] avail_q;
    logic [cnt_w-1:0] held_q;
    logic             credit_q;
    logic             issue;
    logic             push_hit;

    // Region size, bound and base both inclusive
    assign size = cnt_w'(region_cfg[i].bound) - cnt_w'(region_cfg[i].base) + cnt_w'(1);

    assign push_hit = push_valid && (push_id == i);

    // Hand out one credit per cycle while above the withhold level
    assign issue = avail_q > credit_withhold[i];

    // Credit counters
    // In reset the whole region is banked and nothing is out
    // An issued credit moves from avail to held
    // A push consumes a held credit, a free returns one to avail
    always_ff @(posedge clk) begin
      if (int_rst) begin
        avail_q  <= size;
        held_q   <= '0;
        credit_q <= 1'b0;
      end else begin
        avail_q  <= avail_q - cnt_w'(issue) + cnt_w'(free[i]);
        held_q   <= held_q + cnt_w'(issue) - cnt_w'(push_hit);
        credit_q <= issue;
      end
    end

    // Pulse appears one cycle after the decision
    assign push_credit[i] = credit_q;

    assign credit_stat[i] = '{avail: avail_q, held: held_q};

    // Sender only pushes with a credit in hand
    push_has_credit_a: assert property (
      @(posedge clk) disable iff (int_rst)
      push_hit |-> (held_q != '0)
    );

    // Banked plus outstanding credits never exceed the region
    // Entries in the RAM account for the rest
    credit_in_size_a: assert property (
      @(posedge clk) disable iff (int_rst)
      ({1'b0, avail_q} + {1'b0, held_q}) <= {1'b0, size}
    );
  end

endmodule

/* hdl/mfifo_push_ptr.sv */
// Multi-FIFO push pointers that wrap each tail inside its region and form the RAM write
`timescale 1ns/10ps
`include "mfifo_params.svh"

module mfifo_push_ptr
  import mfifo_cfg_pkg::*;
  import mfifo_xfer_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // Merged receiver reset from the credit controller
  input  logic        ptr_clear,
  input  region_map_t region_cfg,
  // Push beat, credit accounting rules out overflow
  input  logic        push_valid,
  input  push_beat_t  push,
  // Write port into the shared RAM
  output ram_wr_t     ram_wr
);

  localparam int num_fifos = `MFIFO_NUM_FIFOS;
  localparam int addr_w    = `MFIFO_ADDR_W;

  logic [num_fifos-1:0][addr_w-1:0] tail;
  region_t                          sel_region;

  for (genvar i = 0; i < num_fifos; i++) begin : gen_tail
    logic [addr_w-1:0] tail_q;
    logic              push_hit;

    assign push_hit = push_valid && (push.id == i);

    // Tail starts at base and wraps from bound back to base
    always_ff @(posedge clk) begin
      if (!rst_n || ptr_clear) begin
        tail_q <= region_cfg[i].base;
      end else if (push_hit) begin
        if (tail_q == region_cfg[i].bound) begin
          tail_q <= region_cfg[i].base;
        end else begin
          tail_q <= tail_q + 1'b1;
        end
      end
    end

    assign tail[i] = tail_q;
  end

  // Write goes out in the push cycle
  assign ram_wr = '{valid: push_valid, addr: tail[push.id], data: push.data};

  // Region of the FIFO being written
  assign sel_region = region_cfg[push.id];

  // Writes never leave the target region
  // Holds only if the tail wrap is right across many pushes
  wr_in_region_a: assert property (
    @(posedge clk) disable iff (!rst_n || ptr_clear)
    ram_wr.valid |-> (ram_wr.addr >= sel_region.base) && (ram_wr.addr <= sel_region.bound)
  );

endmodule

/* hdl/mfifo_pop_ptr.sv */
// Multi-FIFO pop pointers that serve pop strobes, form the RAM read and free entries
`timescale 1ns/10ps
`include "mfifo_params.svh"

module mfifo_pop_ptr
  import mfifo_cfg_pkg::*;
  import mfifo_xfer_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  // Merged receiver reset from the credit controller
  input  logic                        ptr_clear,
  input  region_map_t                 region_cfg,
  // Push strobe, only for occupancy
  input  logic                        push_valid,
  input  logic [`MFIFO_ID_W-1:0]      push_id,
  // Plain pop strobe, no handshake
  input  pop_req_t                    pop,
  // Read port into the shared RAM
  output logic [`MFIFO_ADDR_W-1:0]    rd_addr,
  output logic                        rd_en,
  output logic [`MFIFO_ID_W-1:0]      rd_id,
  // One bit per FIFO, high for each accepted pop
  output logic [`MFIFO_NUM_FIFOS-1:0] free
);

  localparam int num_fifos = `MFIFO_NUM_FIFOS;
  localparam int addr_w    = `MFIFO_ADDR_W;
  localparam int cnt_w     = `MFIFO_CNT_W;

  logic [num_fifos-1:0][addr_w-1:0] head;
  logic [num_fifos-1:0]             nonempty;

  // Pops to an empty FIFO are dropped
  assign rd_en   = pop.valid && nonempty[pop.id];
  assign rd_addr = head[pop.id];
  assign rd_id   = pop.id;

  for (genvar i = 0; i < num_fifos; i++) begin : gen_head
    logic [addr_w-1:0] head_q;
    logic [cnt_w-1:0]  occ_q;
    logic              push_hit;
    logic              pop_hit;

    assign push_hit = push_valid && (push_id == i);
    assign pop_hit  = rd_en && (pop.id == i);

    // Head wraps the same way as the tail
    // Occupancy tracks both strobes locally
    always_ff @(posedge clk) begin
      if (!rst_n || ptr_clear) begin
        head_q <= region_cfg[i].base;
        occ_q  <= '0;
      end else begin
        if (pop_hit) begin
          if (head_q == region_cfg[i].bound) begin
            head_q <= region_cfg[i].base;
          end else begin
            head_q <= head_q + 1'b1;
          end
        end
        occ_q <= occ_q + cnt_w'(push_hit) - cnt_w'(pop_hit);
      end
    end

    assign head[i]     = head_q;
    assign nonempty[i] = occ_q != '0;

    // Each accepted pop frees exactly one entry
    assign free[i] = pop_hit;
  end

endmodule

/* hdl/mfifo_ram.sv */
// Multi-FIFO shared storage with one write port and a registered read port
`timescale 1ns/10ps
`include "mfifo_params.svh"

module mfifo_ram
  import mfifo_xfer_pkg::*;
(
  input  logic                     clk,
  input  ram_wr_t                  ram_wr,
  input  logic                     rd_en,
  input  logic [`MFIFO_ADDR_W-1:0] rd_addr,
  // FIFO id rides along with the read
  input  logic [`MFIFO_ID_W-1:0]   rd_id,
  input  logic                     rst_n,
  output pop_data_t                pop_out
);

  localparam int depth = `MFIFO_DEPTH;
  localparam int width = `MFIFO_WIDTH;
  localparam int id_w  = `MFIFO_ID_W;

  logic [width-1:0] mem [depth];
  logic             rd_vld_q;
  logic [id_w-1:0]  rd_id_q;
  logic [width-1:0] rd_data_q;

  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Valid is the only control bit here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_en;
    end
  end

  // Read data lands one cycle after the pop
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data_q <= mem[rd_addr];
      rd_id_q   <= rd_id;
    end
  end

  assign pop_out = '{valid: rd_vld_q, id: rd_id_q, data: rd_data_q};

endmodule

/* hdl/mfifo_top.sv */
// Multi-FIFO top level joining the credit, push pointer, pop pointer and RAM blocks
`timescale 1ns/10ps
`include "mfifo_params.svh"

module mfifo_top
  import mfifo_cfg_pkg::*;
  import mfifo_xfer_pkg::*;
(
  input  logic                                          clk,
  input  logic                                          rst_n,
  // Credit interface to the sender
  input  logic                                          push_sender_in_reset,
  output logic                                          push_receiver_in_reset,
  output logic [`MFIFO_NUM_FIFOS-1:0]                   push_credit,
  input  logic [`MFIFO_NUM_FIFOS-1:0][`MFIFO_CNT_W-1:0] credit_withhold,
  output credit_stat_vec_t                              credit_stat,
  // Static region map
  input  region_map_t                                   region_cfg,
  // Push side
  input  logic                                          push_valid,
  input  push_beat_t                                    push,
  // Pop side
  input  pop_req_t                                      pop,
  output pop_data_t                                     pop_out
);

  logic                        ptr_clear;
  ram_wr_t                     ram_wr;
  logic                        rd_en;
  logic [`MFIFO_ADDR_W-1:0]    rd_addr;
  logic [`MFIFO_ID_W-1:0]      rd_id;
  logic [`MFIFO_NUM_FIFOS-1:0] free;

  mfifo_credit_ctrl i_credit_ctrl (
    .clk,
    .rst_n,
    .push_sender_in_reset,
    .region_cfg,
    .credit_withhold,
    .push_valid,
    .push_id                (push.id),
    .free,
    .push_credit,
    .push_receiver_in_reset,
    .ptr_clear,
    .credit_stat
  );

  mfifo_push_ptr i_push_ptr (
    .clk,
    .rst_n,
    .ptr_clear,
    .region_cfg,
    .push_valid,
    .push,
    .ram_wr
  );

  mfifo_pop_ptr i_pop_ptr (
    .clk,
    .rst_n,
    .ptr_clear,
    .region_cfg,
    .push_valid,
    .push_id    (push.id),
    .pop,
    .rd_addr,
    .rd_en,
    .rd_id,
    .free
  );

  mfifo_ram i_ram (
    .clk,
    .ram_wr,
    .rd_en,
    .rd_addr,
    .rd_id,
    .rst_n,
    .pop_out
  );

endmodule

/* bench/mfifo_tb_checks.svh */
// Multi-FIFO testbench compare tasks for pop results, credit status and credit tallies
`ifndef MFIFO_TB_CHECKS_SVH
`define MFIFO_TB_CHECKS_SVH

// Id and data only count when a pop result is due
task automatic check_pop(input string name, input pop_data_t got, input pop_data_t exp);
  logic bad;
  bad = (got.valid !== exp.valid);
  if (exp.valid && (got.id !== exp.id || got.data !== exp.data)) begin
    bad = 1'b1;
  end
  if (bad) begin
    $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    err_pop++;
  end
endtask

// Banked and outstanding credits of one FIFO
task automatic check_credit(input string name, input int id, input credit_stat_t got,
                            input credit_stat_t exp);
  if (got !== exp) begin
    $display("ERR %s[%0d] got avail %h held %h expected avail %h held %h", name, id,
             got.avail, got.held, exp.avail, exp.held);
    err_credit++;
  end
endtask

// Credit tallies kept by the bench from the pulses it saw
task automatic check_count(input string name, input int id,
                           input logic [`MFIFO_CNT_W-1:0] got,
                           input logic [`MFIFO_CNT_W-1:0] exp);
  if (got !== exp) begin
    $display("ERR %s[%0d] got %h expected %h", name, id, got, exp);
    err_credit++;
  end
endtask

`endif

/* bench/mfifo_tb.sv */
// Multi-FIFO testbench running file commands through the credit push and strobe pop paths
`timescale 1ns/10ps
`include "mfifo_params.svh"

module mfifo_tb
  import mfifo_cfg_pkg::*;
  import mfifo_xfer_pkg::*;
();

  localparam int num_fifos   = `MFIFO_NUM_FIFOS;
  // Longest credit burst after a reset plus pipeline slack
  localparam int settle_cyc  = `MFIFO_DEPTH + 4;
  localparam int credit_wait = 2 * `MFIFO_DEPTH;

  logic                                          clk = 1'b0;
  logic                                          rst_n;
  logic                                          push_sender_in_reset;
  logic                                          push_receiver_in_reset;
  logic [`MFIFO_NUM_FIFOS-1:0]                   push_credit;
  logic [`MFIFO_NUM_FIFOS-1:0][`MFIFO_CNT_W-1:0] credit_withhold;
  credit_stat_vec_t                              credit_stat;
  region_map_t                                   region_cfg;
  logic                                          push_valid;
  push_beat_t                                    push;
  pop_req_t                                      pop;
  pop_data_t                                     pop_out;

  // Bench view of each FIFO
  int          held_cnt [num_fifos];
  int          pulse_cnt [num_fifos];
  int          occ [num_fifos];
  pop_data_t   exp_pop;
  logic [31:0] lfsr_state;
  int          err_pop;
  int          err_credit;
  int          err_other;
  // Parsed commands, one entry per data line
  logic [7:0]  cmd_q [$];
  int          arg0_q [$];
  int          arg1_q [$];
  bit          cmds_loaded;

  `include "mfifo_tb_checks.svh"

  mfifo_top i_mfifo_top (.*);

  always #20 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Region entries, both ends inclusive
  function automatic int region_size(input int id);
    return int'(region_cfg[id].bound) - int'(region_cfg[id].base) + 1;
  endfunction

  task automatic print_error_counts();
    $display("Errors: %0d pop, %0d credit, %0d other", err_pop, err_credit, err_other);
  endtask

  // One clock sampled at the falling edge where outputs are stable
  task automatic step();
    @(negedge clk);
    for (int i = 0; i < num_fifos; i++) begin
      if (push_credit[i]) begin
        held_cnt[i]++;
        pulse_cnt[i]++;
      end
    end
    // Pop result belongs to the strobe of the previous cycle
    check_pop("pop_out", pop_out, exp_pop);
    exp_pop    = '0;
    push_valid = 1'b0;
    pop        = '0;
  endtask

  // Zero to three idle cycles from two LFSR bits
  task automatic random_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_step(lfsr_state);
      gap        = (gap << 1) | int'(lfsr_state[0]);
    end
    repeat (gap) step();
  endtask

  // A beat only goes out with a credit in hand
  task automatic do_push(input int id, input int data);
    int waited;
    waited = 0;
    while (held_cnt[id] == 0 && waited < credit_wait) begin
      step();
      waited++;
    end
    if (held_cnt[id] == 0) begin
      $display("No push credit arrived for FIFO %0d at %0t", id, $time);
      err_other++;
    end else begin
      push_valid = 1'b1;
      push       = '{id: id[`MFIFO_ID_W-1:0], data: data[`MFIFO_WIDTH-1:0]};
      held_cnt[id]--;
      occ[id]++;
      step();
    end
  endtask

  // Empty pop expects no valid result
  task automatic do_pop(input int id, input bit empty, input int data);
    pop = '{valid: 1'b1, id: id[`MFIFO_ID_W-1:0]};
    if (!empty) begin
      exp_pop = '{valid: 1'b1, id: id[`MFIFO_ID_W-1:0], data: data[`MFIFO_WIDTH-1:0]};
      occ[id]--;
    end
    step();
  endtask

  // Settled state keeps the withhold banked and the rest held or stored
  task automatic compare_credits(input bit after_reset);
    credit_stat_t exp;
    for (int i = 0; i < num_fifos; i++) begin
      exp.avail = credit_withhold[i];
      exp.held  = `MFIFO_CNT_W'(region_size(i) - int'(credit_withhold[i]) - occ[i]);
      check_credit("credit_stat", i, credit_stat[i], exp);
      check_count("held_cnt", i, `MFIFO_CNT_W'(held_cnt[i]), exp.held);
      if (after_reset) begin
        check_count("pulse_cnt", i, `MFIFO_CNT_W'(pulse_cnt[i]), exp.held);
      end
    end
  endtask

  // Sender reset empties the receiver and voids every granted credit
  task automatic sender_reset(input int hold);
    push_sender_in_reset = 1'b1;
    for (int i = 0; i < num_fifos; i++) begin
      held_cnt[i]  = 0;
      pulse_cnt[i] = 0;
      occ[i]       = 0;
    end
    repeat (hold) step();
    if (push_receiver_in_reset !== 1'b1) begin
      $display("Receiver did not report reset while the sender was in reset");
      err_other++;
    end
    push_sender_in_reset = 1'b0;
    repeat (settle_cyc) step();
    if (push_receiver_in_reset !== 1'b0) begin
      $display("Receiver still reports reset after the sender left reset");
      err_other++;
    end
    // Full credit sets come back as after power-up
    compare_credits(1'b1);
  endtask

  // Region lines apply at once and the rest are queued
  task automatic load_commands();
    int         fd;
    int         code;
    int         ch;
    int         a;
    int         b;
    int         c;
    int         d;
    logic [7:0] cmd;
    fd = $fopen("bench/mfifo_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file bench/mfifo_testdata.txt");
      err_other++;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        if (cmd == "#") begin
          ch = $fgetc(fd);
          while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else if (cmd == "C") begin
          code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          if (code != 4) begin
            $display("A region line in the test data is incomplete");
            err_other++;
          end else begin
            region_cfg[a]      = '{base: b[`MFIFO_ADDR_W-1:0], bound: c[`MFIFO_ADDR_W-1:0]};
            credit_withhold[a] = d[`MFIFO_CNT_W-1:0];
          end
        end else begin
          code = $fscanf(fd, "%h", a);
          b    = 0;
          if (code == 1 && (cmd == "P" || cmd == "O")) begin
            code = $fscanf(fd, "%h", b);
          end
          if (code != 1) begin
            $display("Command %c in the test data is missing an argument", cmd);
            err_other++;
          end else begin
            cmd_q.push_back(cmd);
            arg0_q.push_back(a);
            arg1_q.push_back(b);
          end
        end
      end
      $fclose(fd);
    end
    cmds_loaded = 1'b1;
  endtask

  task automatic run_commands();
    for (int n = 0; n < cmd_q.size(); n++) begin
      random_gap();
      case (cmd_q[n])
        "P": do_push(arg0_q[n], arg1_q[n]);
        "O": do_pop(arg0_q[n], 1'b0, arg1_q[n]);
        "E": do_pop(arg0_q[n], 1'b1, 0);
        "I": begin
          repeat (arg0_q[n]) step();
          compare_credits(1'b0);
        end
        "R": sender_reset(arg0_q[n]);
        default: begin
          $display("Unknown command in the test data at entry %0d", n);
          err_other++;
        end
      endcase
    end
  endtask

  initial begin : main
    rst_n                = 1'b0;
    push_sender_in_reset = 1'b0;
    push_valid           = 1'b0;
    push                 = '0;
    pop                  = '0;
    region_cfg           = '0;
    credit_withhold      = '0;
    exp_pop              = '0;
    lfsr_state           = 32'h5dee5b50;
    load_commands();
    // Four rising edges with reset low
    repeat (4) @(negedge clk);
    if (push_receiver_in_reset !== 1'b1 || push_credit !== '0 || pop_out.valid !== 1'b0) begin
      $display("Outputs are not at their reset values while rst_n is low");
      err_other++;
    end
    rst_n = 1'b1;
    repeat (settle_cyc) step();
    compare_credits(1'b1);
    run_commands();
    // Collect the last pop result
    step();
    print_error_counts();
    if (err_pop + err_credit + err_other == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Budget of twenty cycles per command plus reset and settling
  initial begin : watchdog
    wait (cmds_loaded);
    repeat (cmd_q.size() * 20 + 2 * settle_cyc + 24) @(posedge clk);
    $display("Watchdog expired before the command sequence finished");
    err_other++;
    print_error_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

/* mfifo_top.f */
+incdir+hdl
+incdir+bench
hdl/mfifo_cfg_pkg.sv
hdl/mfifo_xfer_pkg.sv
hdl/mfifo_credit_ctrl.sv
hdl/mfifo_push_ptr.sv
hdl/mfifo_pop_ptr.sv
hdl/mfifo_ram.sv
hdl/mfifo_top.sv
bench/mfifo_tb.sv

/* bench/mfifo_testdata.txt */
# Multi-FIFO test data, all numbers hex
# C id base bound withhold sets a region, P id data pushes, O id data pops with expected data
# E id pops an empty FIFO, I cycles idles then checks credits, R cycles holds sender reset
C 0 0 4 1
C 1 5 7 0
C 2 8 b 2
C 3 c f 0
E 0
P 0 1001
P 0 1002
P 1 2001
P 3 4001
P 2 3001
P 0 1003
P 1 2002
O 0 1001
O 1 2001
O 0 1002
P 1 2003
P 1 2004
O 1 2002
O 1 2003
P 1 2005
O 1 2004
O 1 2005
P 1 2006
P 1 2007
O 1 2006
O 1 2007
P 2 3002
O 2 3001
P 2 3003
O 2 3002
O 2 3003
E 2
I 18
O 3 4001
O 0 1003
E 3
P 3 4002
P 0 1004
R 4
E 0
E 3
P 3 4003
O 3 4003
I 18
